//--- rtl/hps_video_pkg.sv
package hps_video_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// Widths with a meaning of their own

	// Pixel or line count
	typedef logic [11:0] dim_t;

	// Aspect term, bit 12 marks a direct size
	typedef logic [12:0] ar_t;

	typedef logic [7:0] cmd_t;

	//////////////////////////////////////////////////////////////////////////////
	// Host command codes

	localparam cmd_t CMD_MODE = 8'h20;
	localparam cmd_t CMD_VSET = 8'h27;
	localparam cmd_t CMD_HSET = 8'h37;
	localparam cmd_t CMD_ARC  = 8'h3A;

	// Output mode after reset, 1080p
	localparam dim_t DEF_WIDTH  = 12'd1920;
	localparam dim_t DEF_HEIGHT = 12'd1080;

	//////////////////////////////////////////////////////////////////////////////
	// Bundles

	typedef struct packed {
		logic        uio;
		logic        strobe;
		logic [15:0] din;
	} host_bus_t;

	typedef struct packed {
		dim_t width;
		dim_t height;
		dim_t hset;
		dim_t vset;
		logic freescale;
		ar_t  arc1x;
		ar_t  arc1y;
		ar_t  arc2x;
		ar_t  arc2y;
	} scale_cfg_t;

	typedef struct packed {
		dim_t hmin;
		dim_t hmax;
		dim_t vmin;
		dim_t vmax;
	} win_t;

	typedef struct packed {
		logic hs;
		logic vs;
	} sync_t;

endpackage

//--- rtl/umuldiv.sv
`timescale 1ns/1ps

module umuldiv #(
	parameter int DIV_W = 12
) (
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_start,
	input  logic [DIV_W-1:0] i_mul1,
	input  logic [DIV_W-1:0] i_mul2,
	input  logic [DIV_W-1:0] i_div,
	output logic             o_busy,
	output logic [DIV_W-1:0] o_result
);

	localparam int STEP_W = $clog2(DIV_W + 1);

	logic [2*DIV_W-1:0] product;
	logic [DIV_W-1:0]   rem, quo, divisor;
	logic               ovf;
	logic [STEP_W-1:0]  step_cnt;
	logic [DIV_W:0]     trial, diff;

	assign product = i_mul1 * i_mul2;

	// Shift next dividend bit into the partial remainder
	assign trial = {rem, quo[DIV_W-1]};
	assign diff  = trial - {1'b0, divisor};

	// Quotient wider than the port saturates
	assign o_result = ovf ? '1 : quo;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy   <= 1'b0;
			step_cnt <= '0;
		end else if (i_start) begin
			o_busy   <= 1'b1;
			step_cnt <= STEP_W'(DIV_W);
		end else if (o_busy) begin
			step_cnt <= step_cnt - 1'b1;
			if (step_cnt == STEP_W'(1)) begin
				o_busy <= 1'b0;
			end
		end
	end

	// Restoring divide, one quotient bit per cycle
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			rem     <= product[2*DIV_W-1:DIV_W];
			quo     <= product[DIV_W-1:0];
			divisor <= i_div;
			ovf     <= product[2*DIV_W-1:DIV_W] >= i_div;
		end else if (o_busy) begin
			rem <= diff[DIV_W] ? trial[DIV_W-1:0] : diff[DIV_W-1:0];
			quo <= {quo[DIV_W-2:0], ~diff[DIV_W]};
		end
	end

endmodule

//--- rtl/ar_window_calc.sv
`timescale 1ns/1ps

module ar_window_calc #(
	parameter int DIV_W = 12
) (
	input  logic                      clk_sys,
	input  logic                      resetd,
	input  hps_video_pkg::scale_cfg_t i_cfg,
	input  hps_video_pkg::ar_t        i_arx,
	input  hps_video_pkg::ar_t        i_ary,
	output hps_video_pkg::win_t       o_win
);

	typedef enum logic [2:0] {
		ST_SELECT,
		ST_MUL_H,
		ST_WAIT_W,
		ST_MUL_W,
		ST_WAIT_H,
		ST_CLAMP,
		ST_CENTRE
	} state_t;

	localparam hps_video_pkg::win_t WIN_FULL = '{
		hmin: '0,
		hmax: hps_video_pkg::DEF_WIDTH - 12'd1,
		vmin: '0,
		vmax: hps_video_pkg::DEF_HEIGHT - 12'd1
	};

	state_t              state;
	hps_video_pkg::dim_t lim_w, lim_h;
	hps_video_pkg::dim_t rat_x, rat_y;
	logic                rat_xy;
	hps_video_pkg::dim_t wcalc, hcalc;
	hps_video_pkg::dim_t videow, videoh;
	hps_video_pkg::win_t win_i;

	logic             md_start;
	logic             md_busy;
	logic [DIV_W-1:0] md_mul1, md_mul2, md_div;
	logic [DIV_W-1:0] md_res;

	umuldiv #(
		.DIV_W(DIV_W)
	) u_muldiv (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_start (md_start),
		.i_mul1  (md_mul1),
		.i_mul2  (md_mul2),
		.i_div   (md_div),
		.o_busy  (md_busy),
		.o_result(md_res)
	);

	//////////////////////////////////////////////////////////////////////////////
	// Host limits and ratio source, one register stage

	always_ff @(posedge clk_sys) begin
		lim_w <= (i_cfg.hset != '0 && i_cfg.hset < i_cfg.width) ? i_cfg.hset : i_cfg.width;
		lim_h <= (i_cfg.vset != '0 && i_cfg.vset < i_cfg.height) ? i_cfg.vset : i_cfg.height;

		// ary of zero picks a custom pair
		if (i_ary == '0 && i_arx == 13'd1) begin
			rat_x  <= i_cfg.arc1x[11:0];
			rat_y  <= i_cfg.arc1y[11:0];
			rat_xy <= i_cfg.arc1x[12] | i_cfg.arc1y[12];
		end else if (i_ary == '0 && i_arx == 13'd2) begin
			rat_x  <= i_cfg.arc2x[11:0];
			rat_y  <= i_cfg.arc2y[11:0];
			rat_xy <= i_cfg.arc2x[12] | i_cfg.arc2y[12];
		end else begin
			rat_x  <= i_arx[11:0];
			rat_y  <= i_ary[11:0];
			rat_xy <= i_arx[12] | i_ary[12];
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// Window loop, runs forever

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= ST_SELECT;
			md_start <= 1'b0;
			win_i    <= WIN_FULL;
		end else begin
			md_start <= 1'b0;
			case (state)
				ST_SELECT: begin
					if (i_cfg.freescale || rat_x == '0 || rat_y == '0) begin
						wcalc <= lim_w;
						hcalc <= lim_h;
						state <= ST_CLAMP;
					end else if (rat_xy) begin
						// Ratio holds the size itself
						wcalc <= rat_x;
						hcalc <= rat_y;
						state <= ST_CLAMP;
					end else begin
						state <= ST_MUL_H;
					end
				end

				// Width from height
				ST_MUL_H: begin
					md_mul1  <= DIV_W'(lim_h);
					md_mul2  <= DIV_W'(rat_x);
					md_div   <= DIV_W'(rat_y);
					md_start <= 1'b1;
					state    <= ST_WAIT_W;
				end
				ST_WAIT_W: begin
					wcalc <= hps_video_pkg::dim_t'(md_res);
					if (!md_start && !md_busy) begin
						state <= ST_MUL_W;
					end
				end

				// Height from width
				ST_MUL_W: begin
					md_mul1  <= DIV_W'(lim_w);
					md_mul2  <= DIV_W'(rat_y);
					md_div   <= DIV_W'(rat_x);
					md_start <= 1'b1;
					state    <= ST_WAIT_H;
				end
				ST_WAIT_H: begin
					hcalc <= hps_video_pkg::dim_t'(md_res);
					if (!md_start && !md_busy) begin
						state <= ST_CLAMP;
					end
				end

				ST_CLAMP: begin
					videow <= (wcalc > lim_w) ? lim_w : wcalc;
					videoh <= (hcalc > lim_h) ? lim_h : hcalc;
					state  <= ST_CENTRE;
				end

				// Centre inside the full output frame
				ST_CENTRE: begin
					win_i.hmin <= (i_cfg.width - videow) >> 1;
					win_i.hmax <= ((i_cfg.width - videow) >> 1) + videow - 12'd1;
					win_i.vmin <= (i_cfg.height - videoh) >> 1;
					win_i.vmax <= ((i_cfg.height - videoh) >> 1) + videoh - 12'd1;
					state      <= ST_SELECT;
				end

				default: state <= ST_SELECT;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_win <= WIN_FULL;
		end else begin
			o_win <= win_i;
		end
	end

endmodule

//--- rtl/hps_cmd_ctrl.sv
`timescale 1ns/1ps

module hps_cmd_ctrl (
	input  logic                      clk_sys,
	input  logic                      resetd,
	input  hps_video_pkg::host_bus_t  i_host,
	output hps_video_pkg::scale_cfg_t o_cfg
);

	typedef enum logic [1:0] {
		IDLE,
		HAVE_CMD,
		DONE_CMD
	} state_t;

	state_t                    state;
	hps_video_pkg::cmd_t       cmd;
	logic [2:0]                word_cnt;
	hps_video_pkg::scale_cfg_t cfg;

	assign o_cfg = cfg;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state         <= IDLE;
			cmd           <= '0;
			word_cnt      <= '0;
			cfg.width     <= hps_video_pkg::DEF_WIDTH;
			cfg.height    <= hps_video_pkg::DEF_HEIGHT;
			cfg.hset      <= '0;
			cfg.vset      <= '0;
			cfg.freescale <= 1'b0;
			cfg.arc1x     <= '0;
			cfg.arc1y     <= '0;
			cfg.arc2x     <= '0;
			cfg.arc2y     <= '0;
		end else if (!i_host.uio) begin
			// Frame closed
			state    <= IDLE;
			cmd      <= '0;
			word_cnt <= '0;
		end else if (i_host.strobe) begin
			case (state)
				IDLE: begin
					// First word of a frame is the command
					cmd      <= i_host.din[7:0];
					word_cnt <= '0;
					if (i_host.din[7:0] inside {hps_video_pkg::CMD_MODE,
							hps_video_pkg::CMD_VSET, hps_video_pkg::CMD_HSET,
							hps_video_pkg::CMD_ARC}) begin
						state <= HAVE_CMD;
					end else begin
						// Unknown, swallow the rest of the frame
						state <= DONE_CMD;
					end
				end

				HAVE_CMD: begin
					word_cnt <= word_cnt + 3'd1;
					case (cmd)
						hps_video_pkg::CMD_MODE: begin
							// Only active size is kept out of the eight mode words
							if (word_cnt == 3'd0) begin
								cfg.width <= i_host.din[11:0];
							end
							if (word_cnt == 3'd4) begin
								cfg.height <= i_host.din[11:0];
							end
							if (word_cnt == 3'd7) begin
								state <= DONE_CMD;
							end
						end

						hps_video_pkg::CMD_VSET: begin
							cfg.vset <= i_host.din[11:0];
							state    <= DONE_CMD;
						end

						hps_video_pkg::CMD_HSET: begin
							cfg.freescale <= i_host.din[15];
							cfg.hset      <= i_host.din[11:0];
							state         <= DONE_CMD;
						end

						hps_video_pkg::CMD_ARC: begin
							case (word_cnt[1:0])
								2'd0: cfg.arc1x <= i_host.din[12:0];
								2'd1: cfg.arc1y <= i_host.din[12:0];
								2'd2: cfg.arc2x <= i_host.din[12:0];
								default: cfg.arc2y <= i_host.din[12:0];
							endcase
							if (word_cnt == 3'd3) begin
								state <= DONE_CMD;
							end
						end

						default: state <= DONE_CMD;
					endcase
				end

				// Extra words until uio drops
				default: state <= DONE_CMD;
			endcase
		end
	end

endmodule

//--- rtl/sync_polarity_fix.sv
`timescale 1ns/1ps

module sync_polarity_fix #(
	parameter int CNT_W = 16
) (
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  hps_video_pkg::sync_t i_sync,
	output hps_video_pkg::sync_t o_sync
);

	logic [1:0] line_in;
	logic [1:0] pol;

	assign line_in = i_sync;
	assign o_sync  = hps_video_pkg::sync_t'(line_in ^ pol);

	// Same measurement for hsync and vsync
	for (genvar i = 0; i < 2; i++) begin : g_line
		logic             s1, s2;
		logic             pol_q;
		logic [CNT_W-1:0] run_cnt;
		logic [CNT_W-1:0] high_len, low_len;

		assign pol[i] = pol_q;

		always_ff @(posedge clk_sys) begin
			if (resetd) begin
				s1       <= 1'b0;
				s2       <= 1'b0;
				run_cnt  <= '0;
				high_len <= '0;
				low_len  <= '0;
				pol_q    <= 1'b0;
			end else begin
				s1 <= line_in[i];
				s2 <= s1;
				if (s1 != s2) begin
					run_cnt <= '0;
				end else if (~&run_cnt) begin
					run_cnt <= run_cnt + 1'b1;
				end
				// Run that just ended
				if (s1 && !s2) begin
					low_len <= run_cnt;
				end
				if (!s1 && s2) begin
					high_len <= run_cnt;
				end
				pol_q <= high_len > low_len;
			end
		end
	end

endmodule

//--- rtl/csync_gen.sv
`timescale 1ns/1ps

module csync_gen #(
	parameter int CNT_W = 16
) (
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  hps_video_pkg::sync_t i_sync,
	output logic                 o_csync
);

	logic             prev_hs;
	logic             cs_hs, cs_vs;
	logic [CNT_W-1:0] h_cnt;
	logic [CNT_W-1:0] line_len, hs_len;

	assign o_csync = cs_hs ^ cs_vs;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			prev_hs <= i_sync.hs;

			// Line and hsync lengths, restarted on each hsync edge
			if (prev_hs != i_sync.hs) begin
				h_cnt <= '0;
				if (i_sync.hs) begin
					line_len <= h_cnt - hs_len;
					cs_hs    <= 1'b0;
				end else begin
					hs_len <= h_cnt;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end

			// In vsync the pulse ends one hsync length early
			if (!i_sync.vs) begin
				cs_hs <= i_sync.hs;
			end else if (h_cnt == line_len) begin
				cs_hs <= 1'b1;
			end

			cs_vs <= i_sync.vs;
		end
	end

endmodule

//--- rtl/hps_video_top.sv
`timescale 1ns/1ps

module hps_video_top #(
	parameter int DIV_W = 12,
	parameter int CNT_W = 16
) (
	input  logic                     clk_sys,
	input  logic                     resetd,
	input  hps_video_pkg::host_bus_t i_host,
	input  hps_video_pkg::ar_t       i_arx,
	input  hps_video_pkg::ar_t       i_ary,
	input  hps_video_pkg::sync_t     i_sync_raw,
	output hps_video_pkg::win_t      o_win,
	output hps_video_pkg::sync_t     o_sync,
	output logic                     o_csync
);

	hps_video_pkg::scale_cfg_t cfg;

	//////////////////////////////////////////////////////////////////////////////
	// Host side

	hps_cmd_ctrl u_cmd_ctrl (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_host (i_host),
		.o_cfg  (cfg)
	);

	ar_window_calc #(
		.DIV_W(DIV_W)
	) u_window (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_cfg  (cfg),
		.i_arx  (i_arx),
		.i_ary  (i_ary),
		.o_win  (o_win)
	);

	//////////////////////////////////////////////////////////////////////////////
	// Sync path

	sync_polarity_fix #(
		.CNT_W(CNT_W)
	) u_sync_fix (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_sync (i_sync_raw),
		.o_sync (o_sync)
	);

	// Composite sync from the normalised pair
	csync_gen #(
		.CNT_W(CNT_W)
	) u_csync (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_sync (o_sync),
		.o_csync(o_csync)
	);

endmodule

//--- tests/hps_video_assert.sv
`timescale 1ns/1ps

module hps_video_assert #(
	parameter bit HOST_CHECKS = 1'b1,
	parameter bit SYNC_CHECKS = 1'b1
) (
	input logic                      clk_sys,
	input logic                      resetd,
	input hps_video_pkg::host_bus_t  i_host,
	input hps_video_pkg::scale_cfg_t i_cfg,
	input hps_video_pkg::sync_t      i_sync,
	input logic                      i_csync
);

	if (HOST_CHECKS) begin : g_host
		// Host strobe is a single-cycle pulse
		a_strobe_pulse: assert property (@(posedge clk_sys) disable iff (resetd)
			i_host.strobe |=> !i_host.strobe)
			else $error("host strobe high on two cycles in a row");

		// Settings move only inside a frame
		a_cfg_hold: assert property (@(posedge clk_sys) disable iff (resetd)
			!i_host.uio |=> $stable(i_cfg))
			else $error("settings changed with uio low");
	end

	if (SYNC_CHECKS) begin : g_sync
		a_csync_follow: assert property (@(posedge clk_sys) disable iff (resetd)
			!i_sync.vs |=> (i_csync == $past(i_sync.hs)))
			else $error("csync does not follow hsync outside vsync");
	end

endmodule

bind hps_cmd_ctrl hps_video_assert #(
	.HOST_CHECKS(1'b1),
	.SYNC_CHECKS(1'b0)
) u_assert (
	.clk_sys(clk_sys),
	.resetd (resetd),
	.i_host (i_host),
	.i_cfg  (o_cfg),
	.i_sync ('0),
	.i_csync(1'b0)
);

bind csync_gen hps_video_assert #(
	.HOST_CHECKS(1'b0),
	.SYNC_CHECKS(1'b1)
) u_assert (
	.clk_sys(clk_sys),
	.resetd (resetd),
	.i_host ('0),
	.i_cfg  ('0),
	.i_sync (i_sync),
	.i_csync(o_csync)
);

//--- tests/tb_hps_video.sv
`timescale 1ns/1ps

module tb_hps_video;

	localparam int NUM_TESTS       = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 5000;
	localparam int SETTLE_CYCLES   = 100;

	// Generated sync pattern that is active low at the input
	localparam int LINE_LEN    = 64;
	localparam int HS_LEN      = 8;
	localparam int FRAME_LINES = 10;
	localparam int VS_LINES    = 2;
	localparam int SYNC_FRAMES = 4;

	logic                      clk_sys;
	logic                      resetd;
	hps_video_pkg::host_bus_t  i_host;
	hps_video_pkg::ar_t        i_arx;
	hps_video_pkg::ar_t        i_ary;
	hps_video_pkg::sync_t      i_sync_raw;
	hps_video_pkg::win_t       o_win;
	hps_video_pkg::sync_t      o_sync;
	logic                      o_csync;

	// Host settings as the model sees them
	int          m_width, m_height, m_hset, m_vset;
	bit          m_freescale;
	int          m_arc[4];
	int          cur_arx, cur_ary;

	logic [31:0] lcg_state;
	logic [15:0] frame_buf[9];
	int          errors, checks, tests_passed;

	hps_video_top #(
		.DIV_W(12),
		.CNT_W(16)
	) dut (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_host    (i_host),
		.i_arx     (i_arx),
		.i_ary     (i_ary),
		.i_sync_raw(i_sync_raw),
		.o_win     (o_win),
		.o_sync    (o_sync),
		.o_csync   (o_csync)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////////////
	// Random numbers and reference model

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(int lo, int hi);
		logic [31:0] r;
		r = next_random();
		return lo + int'((r >> 8) % (hi - lo + 1));
	endfunction

	// Centred window from the host settings and the core ratio
	function automatic hps_video_pkg::win_t model_window(int arx, int ary);
		int                  rx, ry, wl, hl, vw, vh;
		bit                  direct;
		hps_video_pkg::win_t w;
		rx = arx;
		ry = ary;
		if (ary == 0 && (arx == 1 || arx == 2)) begin
			rx = m_arc[2 * (arx - 1)];
			ry = m_arc[2 * (arx - 1) + 1];
		end
		direct = rx[12] || ry[12];
		rx = rx % 4096;
		ry = ry % 4096;
		wl = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
		hl = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
		if (m_freescale || rx == 0 || ry == 0) begin
			vw = wl;
			vh = hl;
		end else if (direct) begin
			vw = rx;
			vh = ry;
		end else begin
			vw = hl * rx / ry;
			vh = wl * ry / rx;
		end
		if (vw > wl) vw = wl;
		if (vh > hl) vh = hl;
		w.hmin = 12'((m_width - vw) / 2);
		w.hmax = 12'((m_width - vw) / 2 + vw - 1);
		w.vmin = 12'((m_height - vh) / 2);
		w.vmax = 12'((m_height - vh) / 2 + vh - 1);
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////////////
	// Host frames

	task automatic send_frame(int n);
		@(posedge clk_sys);
		i_host.uio <= 1'b1;
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
			i_host.strobe <= 1'b1;
			i_host.din    <= frame_buf[i];
			@(posedge clk_sys);
			i_host.strobe <= 1'b0;
		end
		@(posedge clk_sys);
		i_host.uio <= 1'b0;
		i_host.din <= '0;
	endtask

	task automatic send_mode(int w, int h);
		frame_buf[0] = {8'h00, hps_video_pkg::CMD_MODE};
		for (int i = 1; i < 9; i++) begin
			frame_buf[i] = 16'(next_random());
		end
		frame_buf[1] = 16'(w);
		frame_buf[5] = 16'(h);
		m_width  = w;
		m_height = h;
		send_frame(9);
	endtask

	task automatic send_vset(int v);
		frame_buf[0] = {8'h00, hps_video_pkg::CMD_VSET};
		frame_buf[1] = 16'(v);
		m_vset = v;
		send_frame(2);
	endtask

	task automatic send_hset(bit fs, int h);
		frame_buf[0] = {8'h00, hps_video_pkg::CMD_HSET};
		frame_buf[1] = {fs, 3'b000, 12'(h)};
		m_freescale = fs;
		m_hset      = h;
		send_frame(2);
	endtask

	task automatic send_arc(int a0, int a1, int a2, int a3);
		frame_buf[0] = {8'h00, hps_video_pkg::CMD_ARC};
		frame_buf[1] = 16'(a0);
		frame_buf[2] = 16'(a1);
		frame_buf[3] = 16'(a2);
		frame_buf[4] = 16'(a3);
		m_arc[0] = a0;
		m_arc[1] = a1;
		m_arc[2] = a2;
		m_arc[3] = a3;
		send_frame(5);
	endtask

	task automatic set_ratio(int ax, int ay);
		@(posedge clk_sys);
		i_arx <= 13'(ax);
		i_ary <= 13'(ay);
		cur_arx = ax;
		cur_ary = ay;
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// Checking

	task automatic compare_field(string name, logic [15:0] got, logic [15:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
		end
	endtask

	task automatic wait_settle();
		repeat (SETTLE_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic check_window();
		hps_video_pkg::win_t want;
		wait_settle();
		want = model_window(cur_arx, cur_ary);
		compare_field("o_win.hmin", o_win.hmin, want.hmin);
		compare_field("o_win.hmax", o_win.hmax, want.hmax);
		compare_field("o_win.vmin", o_win.vmin, want.vmin);
		compare_field("o_win.vmax", o_win.vmax, want.vmax);
	endtask

	task automatic report_test(int num, string name, int errs_before);
		if (errors == errs_before) begin
			tests_passed++;
			$display("Test %0d %s: ok", num, name);
		end else begin
			$display("Test %0d %s: %0d errors", num, name, errors - errs_before);
		end
	endtask

	// Active low sync in with active high and composite sync out
	task automatic run_sync_test();
		int   total, settle;
		logic want_hs, want_vs, prev_hs, prev_vs;
		total   = SYNC_FRAMES * FRAME_LINES * LINE_LEN;
		settle  = 2 * FRAME_LINES * LINE_LEN;
		prev_hs = 1'b0;
		prev_vs = 1'b0;
		for (int c = 0; c < total; c++) begin
			want_hs = (c % LINE_LEN) < HS_LEN;
			want_vs = ((c / LINE_LEN) % FRAME_LINES) < VS_LINES;
			@(posedge clk_sys);
			i_sync_raw.hs <= !want_hs;
			i_sync_raw.vs <= !want_vs;
			@(negedge clk_sys);
			if (c >= settle) begin
				compare_field("o_sync.hs", 16'(o_sync.hs), 16'(want_hs));
				compare_field("o_sync.vs", 16'(o_sync.vs), 16'(want_vs));
				if (!prev_vs) begin
					compare_field("o_csync", 16'(o_csync), 16'(prev_hs));
				end
			end
			prev_hs = want_hs;
			prev_vs = want_vs;
		end
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : main
		int errs_before;
		int w, h;
		int a[4];
		lcg_state    = 32'h6eae_b0fd;
		errors       = 0;
		checks       = 0;
		tests_passed = 0;
		resetd       = 1'b1;
		i_host       = '0;
		i_arx        = '0;
		i_ary        = '0;
		i_sync_raw   = '0;
		cur_arx      = 0;
		cur_ary      = 0;
		m_width      = 1920;
		m_height     = 1080;
		m_hset       = 0;
		m_vset       = 0;
		m_freescale  = 1'b0;
		for (int k = 0; k < 4; k++) begin
			m_arc[k] = 0;
		end
		repeat (5) @(posedge clk_sys);
		resetd <= 1'b0;

		errs_before = errors;
		wait_settle();
		compare_field("o_win.hmin", o_win.hmin, 16'd0);
		compare_field("o_win.hmax", o_win.hmax, 16'd1919);
		compare_field("o_win.vmin", o_win.vmin, 16'd0);
		compare_field("o_win.vmax", o_win.vmax, 16'd1079);
		report_test(1, "reset window", errs_before);

		// Zero ratio gives the whole frame
		errs_before = errors;
		for (int i = 0; i < 6; i++) begin
			w = rand_range(320, 4095);
			h = rand_range(200, 4095);
			send_mode(w, h);
			wait_settle();
			compare_field("o_win.hmin", o_win.hmin, 16'd0);
			compare_field("o_win.hmax", o_win.hmax, 16'(w - 1));
			compare_field("o_win.vmin", o_win.vmin, 16'd0);
			compare_field("o_win.vmax", o_win.vmax, 16'(h - 1));
		end
		report_test(2, "mode frames", errs_before);

		errs_before = errors;
		for (int i = 0; i < 8; i++) begin
			set_ratio(rand_range(1, 15), rand_range(1, 15));
			check_window();
		end
		report_test(3, "core ratios", errs_before);

		// Limits of zero now and then and freescale on every other pass
		errs_before = errors;
		for (int i = 0; i < 6; i++) begin
			send_vset((rand_range(0, 3) == 0) ? 0 : rand_range(1, 4095));
			send_hset(i[0], (rand_range(0, 3) == 0) ? 0 : rand_range(1, 4095));
			set_ratio(rand_range(1, 15), rand_range(1, 15));
			check_window();
		end
		report_test(4, "host limits", errs_before);

		errs_before = errors;
		send_hset(1'b0, 0);
		send_vset(0);
		for (int i = 0; i < 6; i++) begin
			for (int k = 0; k < 4; k++) begin
				a[k] = (i >= 3) ? (4096 | rand_range(1, 4095)) : rand_range(1, 15);
			end
			send_arc(a[0], a[1], a[2], a[3]);
			set_ratio(1 + (i % 2), 0);
			check_window();
		end
		report_test(5, "custom ratios", errs_before);

		errs_before = errors;
		run_sync_test();
		report_test(6, "sync path", errs_before);

		$display("Tests: %0d of %0d passed, %0d checks, %0d errors",
			tests_passed, NUM_TESTS, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- sources.f
rtl/hps_video_pkg.sv
rtl/umuldiv.sv
rtl/ar_window_calc.sv
rtl/hps_cmd_ctrl.sv
rtl/sync_polarity_fix.sv
rtl/csync_gen.sv
rtl/hps_video_top.sv
tests/hps_video_assert.sv
tests/tb_hps_video.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_hps_video
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
